/* common/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// address split, tag takes what is left of 32 bits
`define CACHE_OFFSET_BITS 5
`define CACHE_INDEX_BITS  4
`define CACHE_TAG_BITS    23

// geometry
`define CACHE_SETS        16
`define CACHE_WAYS        4
`define CACHE_LINE_BITS   256

// valid and dirty bit operations, 2'b11 behaves as idle
`define BITOP_IDLE        2'b00
`define BITOP_SET         2'b01
`define BITOP_CLEAR       2'b10

// data array write enable select
`define DATAWE_NONE       2'b00
`define DATAWE_HIT        2'b01
`define DATAWE_VICTIM     2'b10

`endif

/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

`include "cache_defs.svh"

    // byte address from the cpu or towards memory
    typedef logic [31:0]                      addr_t;

    // address fields
    typedef logic [`CACHE_TAG_BITS-1:0]       tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0]     set_t;

    // whole line and its byte enables
    typedef logic [`CACHE_LINE_BITS-1:0]      line_t;
    typedef logic [`CACHE_LINE_BITS/8-1:0]    byte_mask_t;

    // way number and per-way maps
    typedef logic [$clog2(`CACHE_WAYS)-1:0]   way_t;
    typedef logic [`CACHE_WAYS-1:0]           way_map_t;

    // op code for the valid and dirty arrays
    typedef logic [1:0]                       bit_op_t;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_ALLOCATE
    } cache_state_t;

endpackage

`default_nettype wire

/* common/cache_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface cache_ctrl_if
    import cache_pkg::*;
();
    // valid, dirty and plru updates
    bit_op_t    dirty_op;
    bit_op_t    valid_op;
    logic       plru_update;

    // write steering into the arrays
    logic [1:0] dataweb_sel;
    logic       tagweb_en;
    logic       datain_from_mem;
    logic       use_cpu_mask;

    // read side selects, 0 picks the hit way or the request address
    logic       dataout_victim;
    logic       dirty_way_victim;
    logic       pmem_addr_victim;

    // status back to the fsm
    logic       hit;
    logic       victim_dirty;

    modport ctrl (
        output dirty_op, valid_op, plru_update,
        output dataweb_sel, tagweb_en, datain_from_mem, use_cpu_mask,
        output dataout_victim, dirty_way_victim, pmem_addr_victim,
        input  hit, victim_dirty
    );

    modport dpath (
        input  dirty_op, valid_op, plru_update,
        input  dataweb_sel, tagweb_en, datain_from_mem, use_cpu_mask,
        input  dataout_victim, dirty_way_victim, pmem_addr_victim,
        output hit, victim_dirty
    );

endinterface

`default_nettype wire

/* hw/cache/line_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module line_array
    import cache_pkg::*;
#(
    parameter int WIDTH = `CACHE_LINE_BITS
)(
    input  wire logic             clk,
    input  wire logic             rst_n_i,
    input  wire logic             we_i,
    input  wire byte_mask_t       wmask_i,
    input  wire set_t             set_i,
    input  wire logic [WIDTH-1:0] wdata_i,
    output logic [WIDTH-1:0]      rdata_o
);

    // one entry per set
    logic [WIDTH-1:0] mem [`CACHE_SETS];

    always_ff @(posedge clk) begin
        // no write lands while reset is held
        if (we_i && rst_n_i) begin
            for (int b = 0; b < WIDTH; b++) begin
                // bit b sits in byte b/8, a narrow array only sees the low enables
                if (wmask_i[b/8]) begin
                    mem[set_i][b] <= wdata_i[b];
                end
            end
        end
    end

    // read is async by set
    assign rdata_o = mem[set_i];

endmodule

`default_nettype wire

/* hw/cache/line_state_bits.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module line_state_bits
    import cache_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n_i,
    input  wire bit_op_t op_i,
    input  wire set_t    set_i,
    input  wire way_t    way_i,
    output way_map_t     bits_o
);

    // one bit per way in every set
    way_map_t bits_q [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            // all lines start out invalid and clean
            for (int s = 0; s < `CACHE_SETS; s++) begin
                bits_q[s] <= '0;
            end
        end else begin
            case (op_i)
                `BITOP_SET: begin
                    bits_q[set_i][way_i] <= 1'b1;
                end
                `BITOP_CLEAR: begin
                    bits_q[set_i][way_i] <= 1'b0;
                end
                default: begin
                    // idle, hold
                end
            endcase
        end
    end

    // all ways of the addressed set, async
    assign bits_o = bits_q[set_i];

endmodule

`default_nettype wire

/* hw/cache/plru_tree.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module plru_tree
    import cache_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n_i,
    input  wire logic update_i,
    input  wire set_t set_i,
    input  wire way_t access_way_i,
    output way_t      victim_o,
    output way_map_t  victim_map_o
);

    // [0] root, [1] leaf over ways 0/1, [2] leaf over ways 2/3
    logic [2:0] tree_q [`CACHE_SETS];
    logic [2:0] cur_tree;

    assign cur_tree = tree_q[set_i];

    // walk the tree, 0 means go left
    always_comb begin
        if (!cur_tree[0]) begin
            victim_o = {1'b0, cur_tree[1]};
        end else begin
            victim_o = {1'b1, cur_tree[2]};
        end
    end

    assign victim_map_o = way_map_t'(1) << victim_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (update_i) begin
            // point root and own leaf away from the way just used
            if (!access_way_i[1]) begin
                tree_q[set_i][0] <= 1'b1;
                tree_q[set_i][1] <= ~access_way_i[0];
            end else begin
                tree_q[set_i][0] <= 1'b0;
                tree_q[set_i][2] <= ~access_way_i[0];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cache/cache_datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_datapath
    import cache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    cache_ctrl_if.dpath     ctl,
    input  wire addr_t      cpu_addr_i,
    input  wire line_t      cpu_wdata_i,
    input  wire byte_mask_t cpu_wmask_i,
    input  wire line_t      pmem_rdata_i,
    output line_t           cpu_rdata_o,
    output line_t           pmem_wdata_o,
    output addr_t           pmem_addr_o
);

    localparam int TAG_LSB = `CACHE_OFFSET_BITS + `CACHE_INDEX_BITS;

    // request fields
    tag_t       req_tag;
    set_t       req_set;

    // per-way array outputs
    line_t      data_rd [`CACHE_WAYS];
    tag_t       tag_rd  [`CACHE_WAYS];

    // array write side
    line_t      data_in;
    byte_mask_t data_wmask;
    way_map_t   data_we;
    way_map_t   tag_we;

    // lookup
    way_map_t   hit_map;
    way_t       hit_way;
    way_t       victim_way;
    way_map_t   victim_map;
    way_t       dout_way;
    way_t       dirty_way;
    way_map_t   valid_bits;
    way_map_t   dirty_bits;

    assign req_tag = cpu_addr_i[31:TAG_LSB];
    assign req_set = cpu_addr_i[TAG_LSB-1:`CACHE_OFFSET_BITS];

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        line_array #(.WIDTH(`CACHE_LINE_BITS)) u_data (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .we_i    (data_we[w]),
            .wmask_i (data_wmask),
            .set_i   (req_set),
            .wdata_i (data_in),
            .rdata_o (data_rd[w])
        );
        // tag is always written whole
        line_array #(.WIDTH(`CACHE_TAG_BITS)) u_tag (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .we_i    (tag_we[w]),
            .wmask_i ('1),
            .set_i   (req_set),
            .wdata_i (req_tag),
            .rdata_o (tag_rd[w])
        );
    end

    // valid bits are only ever set on the victim during allocate
    line_state_bits u_valid (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .op_i    (ctl.valid_op),
        .set_i   (req_set),
        .way_i   (victim_way),
        .bits_o  (valid_bits)
    );

    line_state_bits u_dirty (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .op_i    (ctl.dirty_op),
        .set_i   (req_set),
        .way_i   (dirty_way),
        .bits_o  (dirty_bits)
    );

    plru_tree u_plru (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .update_i     (ctl.plru_update),
        .set_i        (req_set),
        .access_way_i (hit_way),
        .victim_o     (victim_way),
        .victim_map_o (victim_map)
    );

    // tag compare, hit_way only meaningful when some way hits
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_map[w] = valid_bits[w] && (tag_rd[w] == req_tag);
            if (hit_map[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // write steering and read selects
    always_comb begin
        case (ctl.dataweb_sel)
            `DATAWE_HIT:    data_we = hit_map;
            `DATAWE_VICTIM: data_we = victim_map;
            default:        data_we = '0;
        endcase
        tag_we     = ctl.tagweb_en ? victim_map : '0;
        // full line on refill
        data_wmask = ctl.use_cpu_mask ? cpu_wmask_i : '1;
        data_in    = ctl.datain_from_mem ? pmem_rdata_i : cpu_wdata_i;
        dout_way   = ctl.dataout_victim ? victim_way : hit_way;
        dirty_way  = ctl.dirty_way_victim ? victim_way : hit_way;
    end

    assign ctl.hit          = |hit_map;
    // dirty is only ever set on a valid line
    assign ctl.victim_dirty = dirty_bits[dirty_way];

    // same read mux feeds cpu and write-back
    assign cpu_rdata_o  = data_rd[dout_way];
    assign pmem_wdata_o = data_rd[dout_way];

    // victim line address is rebuilt from its stored tag
    assign pmem_addr_o = ctl.pmem_addr_victim ?
        {tag_rd[victim_way], req_set, {`CACHE_OFFSET_BITS{1'b0}}} :
        {cpu_addr_i[31:`CACHE_OFFSET_BITS], {`CACHE_OFFSET_BITS{1'b0}}};

endmodule

`default_nettype wire

/* hw/cache/cache_control.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_control
    import cache_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    cache_ctrl_if.ctrl ctl,
    input  wire logic  cpu_read_i,
    input  wire logic  cpu_write_i,
    input  wire logic  pmem_resp_i,
    output logic       cpu_resp_o,
    output logic       pmem_read_o,
    output logic       pmem_write_o
);

    cache_state_t state_q;
    cache_state_t state_d;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        // everything idle unless a state says otherwise
        state_d              = state_q;
        cpu_resp_o           = 1'b0;
        pmem_read_o          = 1'b0;
        pmem_write_o         = 1'b0;
        ctl.dirty_op         = `BITOP_IDLE;
        ctl.valid_op         = `BITOP_IDLE;
        ctl.plru_update      = 1'b0;
        ctl.dataweb_sel      = `DATAWE_NONE;
        ctl.tagweb_en        = 1'b0;
        ctl.datain_from_mem  = 1'b0;
        ctl.use_cpu_mask     = 1'b0;
        ctl.dataout_victim   = 1'b0;
        ctl.dirty_way_victim = 1'b0;
        ctl.pmem_addr_victim = 1'b0;

        case (state_q)
            ST_IDLE: begin
                if (cpu_read_i || cpu_write_i) begin
                    state_d = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                if (ctl.hit) begin
                    // one-cycle response, data comes from the hit way
                    cpu_resp_o      = 1'b1;
                    ctl.plru_update = 1'b1;
                    if (cpu_write_i) begin
                        // merge masked bytes, mark hit way dirty
                        ctl.dataweb_sel  = `DATAWE_HIT;
                        ctl.use_cpu_mask = 1'b1;
                        ctl.dirty_op     = `BITOP_SET;
                    end
                    state_d = ST_IDLE;
                end else begin
                    // miss, look at the victim's dirty bit
                    ctl.dirty_way_victim = 1'b1;
                    if (ctl.victim_dirty) begin
                        state_d = ST_WRITEBACK;
                    end else begin
                        state_d = ST_ALLOCATE;
                    end
                end
            end
            ST_WRITEBACK: begin
                // victim line out at its own address
                pmem_write_o         = 1'b1;
                ctl.pmem_addr_victim = 1'b1;
                ctl.dataout_victim   = 1'b1;
                ctl.dirty_way_victim = 1'b1;
                if (pmem_resp_i) begin
                    state_d = ST_ALLOCATE;
                end
            end
            ST_ALLOCATE: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    // refill victim way, new tag, valid and clean
                    ctl.dataweb_sel      = `DATAWE_VICTIM;
                    ctl.tagweb_en        = 1'b1;
                    ctl.datain_from_mem  = 1'b1;
                    ctl.valid_op         = `BITOP_SET;
                    ctl.dirty_op         = `BITOP_CLEAR;
                    ctl.dirty_way_victim = 1'b1;
                    state_d              = ST_COMPARE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n_i,
    // cpu side
    input  wire addr_t      cpu_addr_i,
    input  wire logic       cpu_read_i,
    input  wire logic       cpu_write_i,
    input  wire line_t      cpu_wdata_i,
    input  wire byte_mask_t cpu_wmask_i,
    output line_t           cpu_rdata_o,
    output logic            cpu_resp_o,
    // physical memory side
    output addr_t           pmem_addr_o,
    output logic            pmem_read_o,
    output logic            pmem_write_o,
    output line_t           pmem_wdata_o,
    input  wire line_t      pmem_rdata_i,
    input  wire logic       pmem_resp_i
);

    // selects and status between fsm and datapath
    cache_ctrl_if ctl_if ();

    cache_control u_control (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ctl          (ctl_if.ctrl),
        .cpu_read_i   (cpu_read_i),
        .cpu_write_i  (cpu_write_i),
        .pmem_resp_i  (pmem_resp_i),
        .cpu_resp_o   (cpu_resp_o),
        .pmem_read_o  (pmem_read_o),
        .pmem_write_o (pmem_write_o)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ctl          (ctl_if.dpath),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_wdata_i  (cpu_wdata_i),
        .cpu_wmask_i  (cpu_wmask_i),
        .pmem_rdata_i (pmem_rdata_i),
        .cpu_rdata_o  (cpu_rdata_o),
        .pmem_wdata_o (pmem_wdata_o),
        .pmem_addr_o  (pmem_addr_o)
    );

endmodule

`default_nettype wire

/* verification/cache_chk.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_chk
    import cache_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n_i,
    input  wire logic  cpu_read_i,
    input  wire logic  cpu_write_i,
    input  wire logic  cpu_resp_i,
    input  wire logic  pmem_read_i,
    input  wire logic  pmem_write_i,
    input  wire addr_t pmem_addr_i
);

    // busy from request sampled in idle until the response edge
    logic busy_q;
    // high during the first compare cycle of a request
    logic compare_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            compare_q <= 1'b0;
        end else begin
            compare_q <= !busy_q && (cpu_read_i || cpu_write_i);
            if (!busy_q) begin
                busy_q <= cpu_read_i || cpu_write_i;
            end else if (cpu_resp_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // response is a single-cycle pulse
    a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        cpu_resp_i |=> !cpu_resp_i)
        else $error("cpu_resp_o held for two cycles");

    // one memory strobe at a time
    a_pmem_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pmem_read_i && pmem_write_i))
        else $error("pmem read and write strobes together");

    // memory is line-wide, so addresses are line aligned
    a_line_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        (pmem_read_i || pmem_write_i) |-> (pmem_addr_i[`CACHE_OFFSET_BITS-1:0] == '0))
        else $error("pmem address not line aligned");

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> (!cpu_resp_i && !pmem_read_i && !pmem_write_i))
        else $error("strobe high in the cycle after reset");

    // no response in the first compare cycle means a miss, memory follows
    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        (compare_q && !cpu_resp_i) |=> (pmem_read_i || pmem_write_i))
        else $error("request out of idle neither answered at 2 cycles nor went to memory");

endmodule

bind cache_top cache_chk u_chk (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cpu_read_i   (cpu_read_i),
    .cpu_write_i  (cpu_write_i),
    .cpu_resp_i   (cpu_resp_o),
    .pmem_read_i  (pmem_read_o),
    .pmem_write_i (pmem_write_o),
    .pmem_addr_i  (pmem_addr_o)
);

`default_nettype wire

/* verification/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_defs.svh"

module cache_tb
    import cache_pkg::*;
();

    localparam int          N_OPS   = 400;
    localparam int          TIMEOUT = 100;
    localparam int unsigned SEED    = 32'hab120532;

    logic       clk;
    logic       rst_n;
    addr_t      cpu_addr;
    logic       cpu_read;
    logic       cpu_write;
    line_t      cpu_wdata;
    byte_mask_t cpu_wmask;
    line_t      cpu_rdata;
    logic       cpu_resp;
    addr_t      pmem_addr;
    logic       pmem_read;
    logic       pmem_write;
    line_t      pmem_wdata;
    line_t      pmem_rdata;
    logic       pmem_resp;

    // reference cache state
    line_t       mdl_data  [`CACHE_SETS][`CACHE_WAYS];
    tag_t        mdl_tag   [`CACHE_SETS][`CACHE_WAYS];
    logic        mdl_valid [`CACHE_SETS][`CACHE_WAYS];
    logic        mdl_dirty [`CACHE_SETS][`CACHE_WAYS];
    logic [2:0]  mdl_plru  [`CACHE_SETS];
    // memory model holds only lines written back
    line_t       mem_model [addr_t];
    tag_t        tag_pool  [8];
    set_t        set_pool  [4];
    int unsigned wb_count;
    int unsigned seed_init;

    cache_top dut0 (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .cpu_addr_i   (cpu_addr),
        .cpu_read_i   (cpu_read),
        .cpu_write_i  (cpu_write),
        .cpu_wdata_i  (cpu_wdata),
        .cpu_wmask_i  (cpu_wmask),
        .cpu_rdata_o  (cpu_rdata),
        .cpu_resp_o   (cpu_resp),
        .pmem_addr_o  (pmem_addr),
        .pmem_read_o  (pmem_read),
        .pmem_write_o (pmem_write),
        .pmem_wdata_o (pmem_wdata),
        .pmem_rdata_i (pmem_rdata),
        .pmem_resp_i  (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // every word of an untouched line mixes in the whole address
    function automatic line_t mem_fill(addr_t a);
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[i*32 +: 32] = a ^ (32'h9e37_79b9 * 32'(i + 1));
        end
        return l;
    endfunction

    function automatic line_t mem_line(addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return mem_fill(a);
    endfunction

    // tree walk where a 0 bit points left
    function automatic way_t plru_victim(logic [2:0] t);
        if (t[0]) begin
            return t[2] ? 2'd3 : 2'd2;
        end
        return t[1] ? 2'd1 : 2'd0;
    endfunction

    // path bits of the used way turn away from it
    function automatic logic [2:0] plru_touched(logic [2:0] t, way_t w);
        logic [2:0] r;
        r = t;
        case (w)
            2'd0: begin
                r[0] = 1'b1;
                r[1] = 1'b1;
            end
            2'd1: begin
                r[0] = 1'b1;
                r[1] = 1'b0;
            end
            2'd2: begin
                r[0] = 1'b0;
                r[2] = 1'b1;
            end
            2'd3: begin
                r[0] = 1'b0;
                r[2] = 1'b0;
            end
        endcase
        return r;
    endfunction

    function automatic line_t merge_bytes(line_t old_l, line_t new_l, byte_mask_t m);
        line_t r;
        r = old_l;
        for (int b = 0; b < 32; b++) begin
            if (m[b]) begin
                r[b*8 +: 8] = new_l[b*8 +: 8];
            end
        end
        return r;
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(string name, logic [255:0] expected, logic [255:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("mismatch %s expected %h actual %h",
                name, expected, actual));
        end
    endtask

    // answer a strobe after 1 to 5 cycles with one resp pulse
    task automatic mem_respond(line_t rdata);
        int unsigned d;
        d = 1 + ($urandom % 5);
        repeat (d) @(posedge clk);
        #2;
        pmem_resp  = 1'b1;
        pmem_rdata = rdata;
        @(posedge clk);
        #2;
        pmem_resp  = 1'b0;
    endtask

    // one cpu access checked against the reference model
    task automatic run_access(int n, logic wr, addr_t a, line_t wd, byte_mask_t wm);
        set_t  s;
        tag_t  t;
        way_t  way;
        addr_t line_a;
        addr_t wb_a;
        logic  hit;
        logic  exp_wb;
        logic  wb_seen;
        logic  rd_seen;
        logic  done;
        int    cycles;
        s      = a[8:5];
        t      = a[31:9];
        line_a = {a[31:5], 5'b0};
        hit    = 1'b0;
        way    = '0;
        exp_wb = 1'b0;
        wb_a   = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (mdl_valid[s][w] && mdl_tag[s][w] == t) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            way    = plru_victim(mdl_plru[s]);
            exp_wb = mdl_valid[s][way] && mdl_dirty[s][way];
            wb_a   = {mdl_tag[s][way], s, 5'b0};
        end
        cpu_addr  = a;
        cpu_read  = !wr;
        cpu_write = wr;
        cpu_wdata = wd;
        cpu_wmask = wm;
        wb_seen   = 1'b0;
        rd_seen   = 1'b0;
        done      = 1'b0;
        cycles    = 0;
        while (!done) begin
            // mid-cycle when outputs have settled
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure($sformatf("op %0d timed out waiting for cpu_resp_o", n));
            end
            if (pmem_write) begin
                if (!exp_wb || wb_seen) begin
                    report_failure($sformatf("op %0d memory write without dirty victim", n));
                end
                check_eq($sformatf("op %0d write-back address", n), 256'(wb_a), 256'(pmem_addr));
                check_eq($sformatf("op %0d write-back data", n), mdl_data[s][way], pmem_wdata);
                mem_model[wb_a] = mdl_data[s][way];
                wb_seen = 1'b1;
                wb_count++;
                mem_respond('0);
            end else if (pmem_read) begin
                if (hit || rd_seen) begin
                    report_failure($sformatf("op %0d memory read not caused by a miss", n));
                end
                if (exp_wb && !wb_seen) begin
                    report_failure($sformatf("op %0d refill before dirty write-back", n));
                end
                check_eq($sformatf("op %0d refill address", n), 256'(line_a), 256'(pmem_addr));
                rd_seen         = 1'b1;
                // refill into the victim as valid and clean
                mdl_data[s][way]  = mem_line(line_a);
                mdl_tag[s][way]   = t;
                mdl_valid[s][way] = 1'b1;
                mdl_dirty[s][way] = 1'b0;
                mem_respond(mdl_data[s][way]);
            end else if (cpu_resp) begin
                done = 1'b1;
            end
        end
        check_eq($sformatf("op %0d write-back seen", n), 256'(exp_wb), 256'(wb_seen));
        check_eq($sformatf("op %0d refill seen", n), 256'(!hit), 256'(rd_seen));
        if (hit) begin
            check_eq($sformatf("op %0d hit latency", n), 256'(2), 256'(cycles));
        end
        // response data is the line before any merge
        check_eq($sformatf("op %0d response data", n), mdl_data[s][way], cpu_rdata);
        mdl_plru[s] = plru_touched(mdl_plru[s], way);
        if (wr) begin
            mdl_data[s][way]  = merge_bytes(mdl_data[s][way], wd, wm);
            mdl_dirty[s][way] = 1'b1;
        end
        @(posedge clk);
        #2;
        cpu_read  = 1'b0;
        cpu_write = 1'b0;
    endtask

    initial begin
        addr_t       a;
        line_t       wd;
        byte_mask_t  wm;
        logic        wr;
        int unsigned idle;
        seed_init  = $urandom(SEED);
        rst_n      = 1'b0;
        cpu_addr   = '0;
        cpu_read   = 1'b0;
        cpu_write  = 1'b0;
        cpu_wdata  = '0;
        cpu_wmask  = '0;
        pmem_rdata = '0;
        pmem_resp  = 1'b0;
        wb_count   = 0;
        // 8 tags on 4 sets of 4 ways make evictions common
        for (int k = 0; k < 8; k++) begin
            tag_pool[k] = tag_t'(32'h0002_4b1 * 32'(k + 1));
        end
        set_pool[0] = 4'd0;
        set_pool[1] = 4'd6;
        set_pool[2] = 4'd9;
        set_pool[3] = 4'd15;
        for (int s = 0; s < `CACHE_SETS; s++) begin
            mdl_plru[s] = 3'b000;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                mdl_data[s][w]  = '0;
                mdl_tag[s][w]   = '0;
                mdl_valid[s][w] = 1'b0;
                mdl_dirty[s][w] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int n = 0; n < N_OPS; n++) begin
            a  = {tag_pool[3'($urandom)], set_pool[2'($urandom)], 5'($urandom)};
            wr = 1'($urandom);
            wm = $urandom;
            for (int i = 0; i < 8; i++) begin
                wd[i*32 +: 32] = $urandom;
            end
            run_access(n, wr, a, wd, wm);
            // occasional idle gap between requests
            idle = $urandom % 3;
            repeat (idle) begin
                @(posedge clk);
                #2;
            end
        end
        if (wb_count == 0) begin
            report_failure("no write-back happened during the whole run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+common
common/cache_pkg.sv
common/cache_ctrl_if.sv
hw/cache/line_array.sv
hw/cache/line_state_bits.sv
hw/cache/plru_tree.sv
hw/cache/cache_datapath.sv
hw/cache/cache_control.sv
hw/cache_top.sv
verification/cache_chk.sv
verification/cache_tb.sv

/* build.sh */
#!/usr/bin/env bash
# compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module cache_tb -f all.f; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vcache_tb)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
